// File: compile.f
logic/cache_pkg.sv
logic/cache_way.sv
logic/four_bank_memory.sv
logic/cache_controller.sv
logic/mem_system.sv
sim/mem_checker.sv
sim/tb_mem_system.sv

// File: Makefile
# Verilator flow for the cache memory system testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_system
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAIL
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails when the log holds the fail message or the binary exits with an error
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit $$status; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_mem_system.sv
// ===============================================
// Testbench for the cache memory system
// Clock, reset, directed and random accesses,
// watchdog and closing summary
// ===============================================

`timescale 1ns/1ps

module tb_mem_system;

   localparam int NUM_DIRECTED = 20;
   localparam int NUM_RANDOM   = 400;
   localparam int CYCLE_LIMIT  = (NUM_DIRECTED + NUM_RANDOM) * 30 + 500;

   logic             clk;
   logic             rst;
   logic             rd;
   logic             wr;
   cache_pkg::addr_t addr;
   cache_pkg::word_t data_in;
   cache_pkg::word_t data_out;
   logic             done;
   logic             stall;
   logic             cache_hit;

   int reads_checked, data_errors, hit_errors, timing_errors, protocol_errors;
   int requests;
   int cycles;
   logic [31:0] rng_state;

   mem_system #(.MEM_LATENCY(2)) UUT (
      .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit)
   );

   mem_checker chk (
      .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit),
      .reads_checked(reads_checked), .data_errors(data_errors), .hit_errors(hit_errors),
      .timing_errors(timing_errors), .protocol_errors(protocol_errors)
   );

   // 10 ns clock
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Byte address from index, tag and word offset
   function automatic cache_pkg::addr_t make_addr(input logic [7:0] idx, input logic [4:0] tg,
                                                  input logic [1:0] off);
      return {idx, tg, off, 1'b0};
   endfunction

   // Few indexes with four tags each so sets overflow
   function automatic cache_pkg::addr_t rand_addr(input logic [31:0] r);
      logic [7:0] idx;
      logic [4:0] tg;
      case (r[1:0])
         2'd0:    idx = 8'h10;
         2'd1:    idx = 8'h11;
         2'd2:    idx = 8'ha0;
         default: idx = 8'hff;
      endcase
      case (r[3:2])
         2'd0:    tg = 5'h00;
         2'd1:    tg = 5'h07;
         2'd2:    tg = 5'h15;
         default: tg = 5'h1f;
      endcase
      // Random bit 0 that the cache ignores
      return {idx, tg, r[5:4], r[6]};
   endfunction

   // One-cycle strobe on the falling edge followed by a wait for done
   task automatic access(input cache_pkg::addr_t a, input logic is_wr,
                         input cache_pkg::word_t d);
      @(negedge clk);
      while (stall) @(negedge clk);
      addr    = a;
      data_in = d;
      rd      = !is_wr;
      wr      = is_wr;
      @(negedge clk);
      rd      = 1'b0;
      wr      = 1'b0;
      // Request already captured so inputs may change
      addr    = ~a;
      data_in = ~d;
      requests++;
      while (!done) @(negedge clk);
   endtask

   task automatic read_word(input cache_pkg::addr_t a);
      access(a, 1'b0, '0);
   endtask

   task automatic write_word(input cache_pkg::addr_t a, input cache_pkg::word_t d);
      access(a, 1'b1, d);
   endtask

   function automatic int error_total();
      return data_errors + hit_errors + timing_errors + protocol_errors;
   endfunction

   task automatic print_summary();
      $write("Summary: %0d requests, %0d reads checked, ", requests, reads_checked);
      $display("errors data %0d hit %0d timing %0d protocol %0d",
               data_errors, hit_errors, timing_errors, protocol_errors);
   endtask

   // Watchdog
   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      print_summary();
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      cache_pkg::addr_t a;
      rst       = 1'b1;
      rd        = 1'b0;
      wr        = 1'b0;
      addr      = '0;
      data_in   = '0;
      requests  = 0;
      rng_state = 32'hf015;
      repeat (10) @(negedge clk);
      rst = 1'b0;

      // Cold reads return zero and miss
      read_word(make_addr(8'h12, 5'h06, 2'd2));
      read_word(16'h0000);

      // Write miss installs the block so later reads hit
      write_word(make_addr(8'h2a, 5'h02, 2'd1), 16'hbeef);
      read_word(make_addr(8'h2a, 5'h02, 2'd1));
      read_word(make_addr(8'h2a, 5'h02, 2'd3));

      // Tag A, tag B, tag A again at one index
      read_word(make_addr(8'h40, 5'h01, 2'd0));
      read_word(make_addr(8'h40, 5'h02, 2'd0));
      read_word(make_addr(8'h40, 5'h01, 2'd1));

      // Clean line evicted ahead of a dirty one
      read_word(make_addr(8'h55, 5'h01, 2'd0));
      write_word(make_addr(8'h55, 5'h02, 2'd2), 16'h1234);
      read_word(make_addr(8'h55, 5'h03, 2'd0));
      read_word(make_addr(8'h55, 5'h02, 2'd2));

      // Four dirty tags through one set force write-back and refill
      for (int t = 0; t < 4; t++) begin
         write_word(make_addr(8'h77, 5'(8 + t), 2'(t)), 16'ha000 + 16'(t));
      end
      for (int t = 0; t < 4; t++) begin
         read_word(make_addr(8'h77, 5'(8 + t), 2'(t)));
      end

      // Random mix over a small address pool
      for (int i = 0; i < NUM_RANDOM; i++) begin
         rng_state = xorshift(rng_state);
         a         = rand_addr(rng_state);
         if (rng_state[7]) begin
            rng_state = xorshift(rng_state);
            write_word(a, rng_state[15:0]);
         end else begin
            read_word(a);
         end
      end

      // Let the checker see the last done
      repeat (4) @(negedge clk);
      print_summary();
      if (error_total() == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: sim/mem_checker.sv
// ===============================================
// Checker for the cache memory system
// Shadow memory, two-way cache state model,
// per-access data, hit and timing comparison
// ===============================================

`timescale 1ns/1ps

module mem_checker (
   input  logic             clk,
   input  logic             rst,
   input  cache_pkg::addr_t addr,
   input  cache_pkg::word_t data_in,
   input  logic             rd,
   input  logic             wr,
   input  cache_pkg::word_t data_out,
   input  logic             done,
   input  logic             stall,
   input  logic             cache_hit,
   output int               reads_checked,
   output int               data_errors,
   output int               hit_errors,
   output int               timing_errors,
   output int               protocol_errors
);

   localparam int DONE_LIMIT   = 64;
   localparam int SHADOW_DEPTH = 1 << 15;

   // Expected hit kinds
   localparam logic [1:0] HIT_NO  = 2'd0;
   localparam logic [1:0] HIT_YES = 2'd1;
   localparam logic [1:0] HIT_ANY = 2'd2;

   // Flat word memory indexed by address bits 15:1
   cache_pkg::word_t shadow [SHADOW_DEPTH];

   // Line state per set and way
   logic            mdl_valid [cache_pkg::NUM_SETS][2];
   logic            mdl_dirty [cache_pkg::NUM_SETS][2];
   cache_pkg::tag_t mdl_tag   [cache_pkg::NUM_SETS][2];
   // Cleared once the toggle bit has picked a victim
   logic            set_known [cache_pkg::NUM_SETS];

   // Outstanding access
   logic             busy;
   logic             busy_wr;
   logic             stall_seen;
   logic             rst_q;
   cache_pkg::addr_t busy_addr;
   cache_pkg::word_t exp_word;
   logic [1:0]       exp_hit;
   int               age;

   // Predicts read word and hit kind and updates the line model
   function automatic void predict(input cache_pkg::addr_t a, input logic is_wr,
                                   output cache_pkg::word_t word, output logic [1:0] kind);
      logic [7:0] idx;
      logic [4:0] tg;
      logic       w;
      logic       have_way;
      idx      = a[15:8];
      tg       = a[7:3];
      word     = shadow[a[15:1]];
      kind     = HIT_NO;
      w        = 1'b0;
      have_way = 1'b1;
      if (!set_known[idx]) begin
         kind     = HIT_ANY;
         have_way = 1'b0;
      end else if (mdl_valid[idx][0] && mdl_tag[idx][0] == tg) begin
         kind = HIT_YES;
      end else if (mdl_valid[idx][1] && mdl_tag[idx][1] == tg) begin
         kind = HIT_YES;
         w    = 1'b1;
      end else if (!mdl_valid[idx][0] || !mdl_valid[idx][1]) begin
         // Invalid way first with way 0 ahead of way 1
         w = mdl_valid[idx][0];
      end else if (!mdl_dirty[idx][0] || !mdl_dirty[idx][1]) begin
         // Then a clean way
         w = mdl_dirty[idx][0];
      end else begin
         // Both dirty so the victim is unknown from here on
         set_known[idx] = 1'b0;
         have_way       = 1'b0;
      end
      if (have_way) begin
         if (kind == HIT_NO) begin
            mdl_valid[idx][w] = 1'b1;
            mdl_dirty[idx][w] = 1'b0;
            mdl_tag[idx][w]   = tg;
         end
         if (is_wr) begin
            mdl_dirty[idx][w] = 1'b1;
         end
      end
   endfunction

   task automatic expect_low(input string name, input logic value);
      if (value !== 1'b0) begin
         $display("[ERROR] %0t ns %s after reset: expected 0, got %b", $time, name, value);
         protocol_errors++;
      end
   endtask

   // Done cycle of the outstanding access
   task automatic compare_result();
      logic fast;
      if (!busy_wr) begin
         reads_checked++;
         if (data_out !== exp_word) begin
            $display("[ERROR] %0t ns data_out: expected %h, got %h (addr %h)",
                     $time, exp_word, data_out, busy_addr);
            data_errors++;
         end
      end
      if (exp_hit != HIT_ANY && cache_hit !== exp_hit[0]) begin
         $display("[ERROR] %0t ns cache_hit: expected %b, got %b (addr %h)",
                  $time, exp_hit[0], cache_hit, busy_addr);
         hit_errors++;
      end
      // Model picks the timing unless the set state is unknown
      if (exp_hit == HIT_ANY) begin
         fast = cache_hit;
      end else begin
         fast = exp_hit[0];
      end
      if (fast === 1'b1) begin
         // Hit completes one edge after acceptance
         if (age != 1) begin
            $display("[ERROR] %0t ns done latency: expected 1, got %0d", $time, age);
            timing_errors++;
         end
         if (stall_seen) begin
            $display("[ERROR] %0t ns stall: expected 0, got 1 during a hit", $time);
            timing_errors++;
         end
      end else if (!stall_seen) begin
         $display("[ERROR] %0t ns stall: expected 1, got 0 during a miss", $time);
         timing_errors++;
      end
      if (stall !== 1'b0) begin
         $display("[ERROR] %0t ns stall: expected 0, got %b in the done cycle", $time, stall);
         timing_errors++;
      end
   endtask

   always @(posedge clk) begin
      if (rst) begin
         busy            = 1'b0;
         rst_q           = 1'b1;
         reads_checked   = 0;
         data_errors     = 0;
         hit_errors      = 0;
         timing_errors   = 0;
         protocol_errors = 0;
         for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
            mdl_valid[s][0] = 1'b0;
            mdl_valid[s][1] = 1'b0;
            mdl_dirty[s][0] = 1'b0;
            mdl_dirty[s][1] = 1'b0;
            set_known[s]    = 1'b1;
         end
         // Main memory starts at zero
         for (int i = 0; i < SHADOW_DEPTH; i++) begin
            shadow[i] = '0;
         end
      end else begin
         // First edge out of reset
         if (rst_q) begin
            expect_low("done", done);
            expect_low("stall", stall);
            expect_low("cache_hit", cache_hit);
         end
         rst_q = 1'b0;
         if (busy && done) begin
            compare_result();
            busy = 1'b0;
         end else if (busy) begin
            age++;
            if (stall) begin
               stall_seen = 1'b1;
            end
            if (age > DONE_LIMIT) begin
               $display("No done pulse within %0d cycles of the request to address %h",
                        DONE_LIMIT, busy_addr);
               protocol_errors++;
               busy = 1'b0;
            end
         end else if (done) begin
            $display("Unexpected done pulse at %0t ns with no request outstanding", $time);
            protocol_errors++;
         end
         // Accepted request
         if (!busy && (rd || wr) && !stall) begin
            busy       = 1'b1;
            busy_wr    = wr;
            busy_addr  = addr;
            age        = 0;
            stall_seen = 1'b0;
            predict(addr, wr, exp_word, exp_hit);
            if (wr) begin
               shadow[addr[15:1]] = data_in;
            end
         end
      end
   end

endmodule

// File: logic/mem_system.sv
// ===============================================
// Memory system top level
// Two cache ways, controller and banked memory
// ===============================================

`timescale 1ns/1ps

module mem_system #(
   parameter int MEM_LATENCY = 2
) (
   input  logic             clk,
   input  logic             rst,
   input  cache_pkg::addr_t addr,
   input  cache_pkg::word_t data_in,
   input  logic             rd,
   input  logic             wr,
   output cache_pkg::word_t data_out,
   output logic             done,
   output logic             stall,
   output logic             cache_hit
);

   // Way results
   logic               way0_hit, way0_valid, way0_dirty;
   logic               way1_hit, way1_valid, way1_dirty;
   cache_pkg::tag_t    way0_tag, way1_tag;
   cache_pkg::word_t   way0_data, way1_data;

   // Shared way controls
   logic               way0_enable, way1_enable;
   logic               way_compare, way_write;
   cache_pkg::index_t  way_index;
   cache_pkg::tag_t    way_tag;
   cache_pkg::offset_t way_offset;
   cache_pkg::word_t   way_write_data;

   // Memory port
   cache_pkg::addr_t   mem_addr;
   cache_pkg::word_t   mem_write_data, mem_read_data;
   logic               mem_rd, mem_wr;

   cache_way way0 (
      .clk(clk), .rst(rst), .enable(way0_enable), .compare(way_compare), .write(way_write),
      .index(way_index), .tag(way_tag), .offset(way_offset), .write_data(way_write_data),
      .hit(way0_hit), .valid(way0_valid), .dirty(way0_dirty),
      .stored_tag(way0_tag), .read_data(way0_data)
   );

   cache_way way1 (
      .clk(clk), .rst(rst), .enable(way1_enable), .compare(way_compare), .write(way_write),
      .index(way_index), .tag(way_tag), .offset(way_offset), .write_data(way_write_data),
      .hit(way1_hit), .valid(way1_valid), .dirty(way1_dirty),
      .stored_tag(way1_tag), .read_data(way1_data)
   );

   four_bank_memory #(.MEM_LATENCY(MEM_LATENCY)) mem (
      .clk(clk), .rst(rst), .mem_addr(mem_addr), .mem_write_data(mem_write_data),
      .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_read_data(mem_read_data)
   );

   cache_controller #(.MEM_LATENCY(MEM_LATENCY)) ctrl (
      .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .way0_hit(way0_hit), .way0_valid(way0_valid), .way0_dirty(way0_dirty),
      .way1_hit(way1_hit), .way1_valid(way1_valid), .way1_dirty(way1_dirty),
      .way0_tag(way0_tag), .way1_tag(way1_tag), .way0_data(way0_data), .way1_data(way1_data),
      .way0_enable(way0_enable), .way1_enable(way1_enable),
      .way_compare(way_compare), .way_write(way_write), .way_index(way_index),
      .way_tag(way_tag), .way_offset(way_offset), .way_write_data(way_write_data),
      .mem_addr(mem_addr), .mem_write_data(mem_write_data), .mem_rd(mem_rd),
      .mem_wr(mem_wr), .mem_read_data(mem_read_data),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit)
   );

endmodule

// File: logic/cache_controller.sv
// ===============================================
// Cache controller FSM with lookup, write-back,
// pipelined fill and retry, victim choice and
// registered outputs
// ===============================================

`timescale 1ns/1ps

module cache_controller #(
   parameter int MEM_LATENCY = 2
) (
   input  logic               clk,
   input  logic               rst,
   input  cache_pkg::addr_t   addr,
   input  cache_pkg::word_t   data_in,
   input  logic               rd,
   input  logic               wr,
   input  logic               way0_hit,
   input  logic               way0_valid,
   input  logic               way0_dirty,
   input  logic               way1_hit,
   input  logic               way1_valid,
   input  logic               way1_dirty,
   input  cache_pkg::tag_t    way0_tag,
   input  cache_pkg::tag_t    way1_tag,
   input  cache_pkg::word_t   way0_data,
   input  cache_pkg::word_t   way1_data,
   output logic               way0_enable,
   output logic               way1_enable,
   output logic               way_compare,
   output logic               way_write,
   output cache_pkg::index_t  way_index,
   output cache_pkg::tag_t    way_tag,
   output cache_pkg::offset_t way_offset,
   output cache_pkg::word_t   way_write_data,
   output cache_pkg::addr_t   mem_addr,
   output cache_pkg::word_t   mem_write_data,
   output logic               mem_rd,
   output logic               mem_wr,
   input  cache_pkg::word_t   mem_read_data,
   output cache_pkg::word_t   data_out,
   output logic               done,
   output logic               stall,
   output logic               cache_hit
);

   cache_pkg::ctrl_state_t state;

   // Captured request
   cache_pkg::addr_t   req_addr;
   cache_pkg::word_t   req_data;
   logic               req_wr;
   logic               pend;
   cache_pkg::index_t  req_index;
   cache_pkg::tag_t    req_tag;
   cache_pkg::offset_t req_offset;

   // Replacement
   logic               victim;
   logic               toggle;
   logic               next_victim;
   logic               victim_dirty;
   cache_pkg::tag_t    victim_tag;

   // Word counters for write-back/fill
   logic [2:0]             issue_cnt;
   logic [1:0]             inst_cnt;
   logic [MEM_LATENCY-1:0] ret_pipe;

   logic accept;
   logic any_hit;

   assign req_index  = req_addr[cache_pkg::INDEX_LSB +: cache_pkg::INDEX_W];
   assign req_tag    = req_addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];
   assign req_offset = req_addr[cache_pkg::OFFSET_LSB +: cache_pkg::OFFSET_W];

   // New request only when idle with nothing pending
   assign accept  = (state == cache_pkg::ST_IDLE) && !pend && !stall && (rd || wr);
   assign any_hit = way0_hit || way1_hit;

   // Invalid way first, then clean way, then the toggle bit
   always_comb begin
      if (!way0_valid) begin
         next_victim = 1'b0;
      end else if (!way1_valid) begin
         next_victim = 1'b1;
      end else if (!way0_dirty) begin
         next_victim = 1'b0;
      end else if (!way1_dirty) begin
         next_victim = 1'b1;
      end else begin
         next_victim = toggle;
      end
   end

   // Write-back needed only when both lines are valid and dirty
   assign victim_dirty = way0_valid && way1_valid && way0_dirty && way1_dirty;
   assign victim_tag   = victim ? way1_tag : way0_tag;

   // Way and memory drive
   always_comb begin
      way0_enable    = 1'b0;
      way1_enable    = 1'b0;
      way_compare    = 1'b0;
      way_write      = 1'b0;
      way_index      = req_index;
      way_tag        = req_tag;
      way_offset     = req_offset;
      way_write_data = req_data;
      mem_addr       = '0;
      mem_write_data = victim ? way1_data : way0_data;
      mem_rd         = 1'b0;
      mem_wr         = 1'b0;
      unique case (state)
         cache_pkg::ST_IDLE, cache_pkg::ST_RETRY: begin
            // Lookup on both ways, hit write sets dirty
            if (pend || state == cache_pkg::ST_RETRY) begin
               way0_enable = 1'b1;
               way1_enable = 1'b1;
               way_compare = 1'b1;
               way_write   = req_wr;
            end
         end
         cache_pkg::ST_WRITE_BACK: begin
            // Stream victim block back to its old address
            way0_enable = !victim;
            way1_enable = victim;
            way_offset  = issue_cnt[1:0];
            mem_wr      = 1'b1;
            mem_addr    = {req_index, victim_tag, issue_cnt[1:0], 1'b0};
         end
         cache_pkg::ST_FILL: begin
            // One read per cycle until four issued
            mem_rd   = !issue_cnt[2];
            mem_addr = {req_index, req_tag, issue_cnt[1:0], 1'b0};
            // Install returning word into the victim
            if (ret_pipe[MEM_LATENCY-1]) begin
               way0_enable    = !victim;
               way1_enable    = victim;
               way_write      = 1'b1;
               way_offset     = inst_cnt;
               way_write_data = mem_read_data;
            end
         end
         default: begin
         end
      endcase
   end

   // Control state
   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= cache_pkg::ST_IDLE;
         pend      <= 1'b0;
         victim    <= 1'b0;
         toggle    <= 1'b0;
         issue_cnt <= '0;
         inst_cnt  <= '0;
         ret_pipe  <= '0;
         done      <= 1'b0;
         stall     <= 1'b0;
         cache_hit <= 1'b0;
      end else begin
         toggle    <= ~toggle;
         done      <= 1'b0;
         cache_hit <= 1'b0;
         // Track reads in flight
         ret_pipe[0] <= mem_rd;
         for (int i = 1; i < MEM_LATENCY; i++) begin
            ret_pipe[i] <= ret_pipe[i-1];
         end
         if (accept) begin
            pend <= 1'b1;
         end
         unique case (state)
            cache_pkg::ST_IDLE: begin
               if (pend) begin
                  pend <= 1'b0;
                  if (any_hit) begin
                     done      <= 1'b1;
                     cache_hit <= 1'b1;
                  end else begin
                     victim <= next_victim;
                     stall  <= 1'b1;
                     state  <= victim_dirty ? cache_pkg::ST_WRITE_BACK : cache_pkg::ST_FILL;
                  end
               end
            end
            cache_pkg::ST_WRITE_BACK: begin
               issue_cnt <= issue_cnt + 3'd1;
               if (issue_cnt[1:0] == 2'd3) begin
                  issue_cnt <= '0;
                  state     <= cache_pkg::ST_FILL;
               end
            end
            cache_pkg::ST_FILL: begin
               if (mem_rd) begin
                  issue_cnt <= issue_cnt + 3'd1;
               end
               if (ret_pipe[MEM_LATENCY-1]) begin
                  inst_cnt <= inst_cnt + 2'd1;
                  // Last word installed
                  if (inst_cnt == 2'd3) begin
                     issue_cnt <= '0;
                     state     <= cache_pkg::ST_RETRY;
                  end
               end
            end
            cache_pkg::ST_RETRY: begin
               state <= cache_pkg::ST_IDLE;
               done  <= 1'b1;
               stall <= 1'b0;
            end
            default: state <= cache_pkg::ST_IDLE;
         endcase
      end
   end

   // Request capture and read data
   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
      if ((state == cache_pkg::ST_IDLE && pend) || state == cache_pkg::ST_RETRY) begin
         data_out <= way0_hit ? way0_data : way1_data;
      end
   end

endmodule

// File: logic/four_bank_memory.sv
// ===============================================
// Word-interleaved four-bank main memory
// Pipelined reads with fixed MEM_LATENCY
// ===============================================

`timescale 1ns/1ps

module four_bank_memory #(
   parameter int MEM_LATENCY = 2
) (
   input  logic             clk,
   input  logic             rst,
   input  cache_pkg::addr_t mem_addr,
   input  cache_pkg::word_t mem_write_data,
   input  logic             mem_rd,
   input  logic             mem_wr,
   output cache_pkg::word_t mem_read_data
);

   localparam int NUM_BANKS = cache_pkg::WORDS_PER_BLOCK;
   localparam int ROW_LSB   = cache_pkg::OFFSET_LSB + cache_pkg::OFFSET_W;
   localparam int ROW_W     = cache_pkg::ADDR_W - ROW_LSB;
   localparam int BANK_DEPTH = 1 << ROW_W;

   cache_pkg::offset_t bank_sel;
   logic [ROW_W-1:0]   row;

   // Read word from every bank at the current row
   cache_pkg::word_t   bank_rdata [NUM_BANKS];

   // Read return pipeline
   cache_pkg::word_t   rd_pipe [MEM_LATENCY];

   // Low offset bits pick the bank
   assign bank_sel = mem_addr[cache_pkg::OFFSET_LSB +: cache_pkg::OFFSET_W];
   assign row      = mem_addr[ROW_LSB +: ROW_W];

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      cache_pkg::word_t bank_mem [BANK_DEPTH];

      // Contents start at zero
      initial begin
         for (int i = 0; i < BANK_DEPTH; i++) begin
            bank_mem[i] = '0;
         end
      end

      always_ff @(posedge clk) begin
         if (mem_wr && (bank_sel == b)) begin
            bank_mem[row] <= mem_write_data;
         end
      end

      assign bank_rdata[b] = bank_mem[row];
   end

   // Stage 0 samples the bank, later stages shift
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < MEM_LATENCY; s++) begin
            rd_pipe[s] <= '0;
         end
      end else begin
         rd_pipe[0] <= mem_rd ? bank_rdata[bank_sel] : '0;
         for (int s = 1; s < MEM_LATENCY; s++) begin
            rd_pipe[s] <= rd_pipe[s-1];
         end
      end
   end

   // Data appears MEM_LATENCY edges after issue
   assign mem_read_data = rd_pipe[MEM_LATENCY-1];

endmodule

// File: logic/cache_way.sv
// ===============================================
// One cache way with tag, valid, dirty and data
// arrays, tag compare and write control
// ===============================================

`timescale 1ns/1ps

module cache_way (
   input  logic               clk,
   input  logic               rst,
   input  logic               enable,
   input  logic               compare,
   input  logic               write,
   input  cache_pkg::index_t  index,
   input  cache_pkg::tag_t    tag,
   input  cache_pkg::offset_t offset,
   input  cache_pkg::word_t   write_data,
   output logic               hit,
   output logic               valid,
   output logic               dirty,
   output cache_pkg::tag_t    stored_tag,
   output cache_pkg::word_t   read_data
);

   localparam int DATA_DEPTH = cache_pkg::NUM_SETS * cache_pkg::WORDS_PER_BLOCK;
   localparam int SEL_W      = cache_pkg::INDEX_W + cache_pkg::OFFSET_W;

   // Tag and data storage
   cache_pkg::tag_t  tag_mem  [cache_pkg::NUM_SETS];
   cache_pkg::word_t data_mem [DATA_DEPTH];

   // Per-set line state
   logic [cache_pkg::NUM_SETS-1:0] valid_bits;
   logic [cache_pkg::NUM_SETS-1:0] dirty_bits;

   logic [SEL_W-1:0] word_sel;
   logic             fill_wr;
   logic             hit_wr;

   // Word address inside the data array
   assign word_sel = {index, offset};

   // Combinational lookup
   assign stored_tag = tag_mem[index];
   assign read_data  = data_mem[word_sel];
   assign valid      = valid_bits[index];
   assign dirty      = dirty_bits[index];

   // Hit only while selected
   assign hit = enable && valid && (stored_tag == tag);

   // Fill write loads the line unconditionally
   assign fill_wr = enable && write && !compare;
   // Compare write lands only on a tag hit
   assign hit_wr  = write && compare && hit;

   always_ff @(posedge clk) begin
      if (fill_wr || hit_wr) begin
         data_mem[word_sel] <= write_data;
      end
      if (fill_wr) begin
         tag_mem[index] <= tag;
      end
   end

   // Valid and dirty bits
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else begin
         if (fill_wr) begin
            // Freshly filled line is clean
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;
         end else if (hit_wr) begin
            dirty_bits[index] <= 1'b1;
         end
      end
   end

endmodule

// File: logic/cache_pkg.sv
// ===============================================
// Shared types and constants for the cache system
// Address field layout, vector typedefs, FSM enum
// ===============================================

package cache_pkg;

   // Bus widths
   localparam int ADDR_W = 16;
   localparam int WORD_W = 16;

   // Address fields, byte address with bit 0 unused
   localparam int OFFSET_LSB = 1;
   localparam int OFFSET_W   = 2;
   localparam int TAG_LSB    = 3;
   localparam int TAG_W      = 5;
   localparam int INDEX_LSB  = 8;
   localparam int INDEX_W    = 8;

   // Cache geometry
   localparam int WORDS_PER_BLOCK = 4;
   localparam int NUM_SETS        = 256;

   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [WORD_W-1:0]   word_t;
   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [OFFSET_W-1:0] offset_t;

   // Controller FSM
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WRITE_BACK,
      ST_FILL,
      ST_RETRY
   } ctrl_state_t;

endpackage
